// File: cfg_reader_pkg.sv
// Engine configuration reader definitions
package cfg_reader_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_W  = 32;
    localparam int INDEX_W = 16;
    localparam int POS_W   = 4;
    localparam int KIND_W  = 4;
    localparam int CMD_W   = 4;
    localparam int BUF_W   = 4;
    localparam int SHIFT_W = DATA_W - 1;
    localparam int PTR_W   = 2 * DATA_W;

    // Setup kinds accepted by the filter
    localparam logic [KIND_W-1:0] KIND_CU_SETUP     = KIND_W'(1);
    localparam logic [KIND_W-1:0] KIND_ENGINE_SETUP = KIND_W'(2);

    // ----------------------------------------
    // Window positions
    // ----------------------------------------
    localparam logic [POS_W-1:0] POS_FLAGS       = POS_W'(0);
    localparam logic [POS_W-1:0] POS_INDEX_START = POS_W'(1);
    localparam logic [POS_W-1:0] POS_INDEX_END   = POS_W'(2);
    localparam logic [POS_W-1:0] POS_STRIDE      = POS_W'(3);
    localparam logic [POS_W-1:0] POS_GRANULARITY = POS_W'(4);
    localparam logic [POS_W-1:0] POS_SUBCLASS    = POS_W'(5);
    localparam logic [POS_W-1:0] POS_PTR_LO      = POS_W'(8);
    localparam logic [POS_W-1:0] POS_PTR_HI      = POS_W'(9);
    localparam logic [POS_W-1:0] POS_ARRAY_SIZE  = POS_W'(10);
    // Closes a record
    localparam logic [POS_W-1:0] POS_LAST        = POS_W'(15);

    // ----------------------------------------
    // Record layout, LSB first
    // ----------------------------------------
    localparam int OFF_INCREMENT     = 0;
    localparam int OFF_DECREMENT     = OFF_INCREMENT + 1;
    localparam int OFF_MODE_SEQUENCE = OFF_DECREMENT + 1;
    localparam int OFF_MODE_BUFFER   = OFF_MODE_SEQUENCE + 1;
    localparam int OFF_INDEX_START   = OFF_MODE_BUFFER + 1;
    localparam int OFF_INDEX_END     = OFF_INDEX_START + DATA_W;
    localparam int OFF_STRIDE        = OFF_INDEX_END + DATA_W;
    localparam int OFF_SHIFT_AMOUNT  = OFF_STRIDE + DATA_W;
    localparam int OFF_SHIFT_LEFT    = OFF_SHIFT_AMOUNT + SHIFT_W;
    localparam int OFF_CMD           = OFF_SHIFT_LEFT + 1;
    localparam int OFF_BUFFER        = OFF_CMD + CMD_W;
    localparam int OFF_ARRAY_POINTER = OFF_BUFFER + BUF_W;
    localparam int OFF_ARRAY_SIZE    = OFF_ARRAY_POINTER + PTR_W;
    localparam int RECORD_W          = OFF_ARRAY_SIZE + DATA_W;

    // One setup word, seen as flags, as a shift or as a subclass
    typedef union packed {
        logic [DATA_W-1:0] word;
        struct packed {
            logic [DATA_W-5:0] reserved;
            logic              mode_buffer;
            logic              mode_sequence;
            logic              decrement;
            logic              increment;
        } flags;
        struct packed {
            logic               direction;  // 1 is left
            logic [SHIFT_W-1:0] amount;
        } shift;
        struct packed {
            logic [DATA_W-CMD_W-BUF_W-1:0] reserved;
            logic [BUF_W-1:0]              buffer;
            logic [CMD_W-1:0]              cmd;
        } subclass;
    } setup_word_u;

endpackage

// File: word_stream_if.sv
// Positioned setup word stream
interface word_stream_if import cfg_reader_pkg::*; ();

    logic              valid;
    logic              ready;
    logic [POS_W-1:0]  pos;
    logic [DATA_W-1:0] data;

    modport src (
        output valid,
        output pos,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  pos,
        input  data,
        output ready
    );

    // Passive view of the current word
    modport monitor (
        input pos,
        input data
    );

endinterface

// File: setup_word_filter.sv
// Setup word input filter
module setup_word_filter import cfg_reader_pkg::*; #(
    parameter int SEQ_BASE = 0
) (
    input  logic               ap_clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [KIND_W-1:0]  in_kind,
    input  logic [INDEX_W-1:0] in_index,
    input  logic [DATA_W-1:0]  in_data,
    word_stream_if.src         out
);

    localparam int WINDOW = 2 ** POS_W;

    logic             kind_ok;
    logic             in_window;
    logic             keep;
    logic [POS_W-1:0] window_pos;

    // ----------------------------------------
    // Word selection
    // ----------------------------------------
    assign kind_ok    = (in_kind == KIND_CU_SETUP) || (in_kind == KIND_ENGINE_SETUP);
    assign in_window  = (in_index >= SEQ_BASE) && (in_index < SEQ_BASE + WINDOW);
    assign keep       = kind_ok && in_window;
    assign window_pos = POS_W'(in_index - INDEX_W'(SEQ_BASE));

    // Rejected words are still taken, then dropped
    assign in_ready = !out.valid || out.ready;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (in_ready) begin
            out.valid <= in_valid && keep;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_ready && in_valid && keep) begin
            out.pos  <= window_pos;
            out.data <= in_data;
        end
    end

endmodule

// File: word_fifo.sv
// Setup word queue
module word_fifo import cfg_reader_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic       ap_clk,
    input  logic       rst,
    word_stream_if.dst in,
    word_stream_if.src out
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [POS_W-1:0]    pos_mem  [DEPTH];
    logic [DATA_W-1:0]   data_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    assign in.ready  = (count < CNT_BITS'(DEPTH));
    assign out.valid = (count != '0);
    assign out.pos   = pos_mem[rd_ptr];
    assign out.data  = data_mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // ----------------------------------------
    // Pointers and fill count
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            pos_mem[wr_ptr]  <= in.pos;
            data_mem[wr_ptr] <= in.data;
        end
    end

endmodule

// File: config_assembler_ctrl.sv
// Configuration assembly control
module config_assembler_ctrl import cfg_reader_pkg::*; (
    input  logic       ap_clk,
    input  logic       rst,
    word_stream_if.dst words,
    input  logic       record_almost_full,
    output logic       field_load,
    output logic       record_push
);

    logic pop;
    logic closing;

    // ----------------------------------------
    // Word pop
    // ----------------------------------------
    // Hold words back while the record queue is nearly full
    assign words.ready = !record_almost_full;
    assign pop         = words.valid && words.ready;
    assign closing     = pop && (words.pos == POS_LAST);

    // Decoder writes the field on the same edge as the pop
    assign field_load = pop;

    // ----------------------------------------
    // Record push
    // ----------------------------------------
    // One cycle late, so the decoder has taken the closing word
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            record_push <= 1'b0;
        end else begin
            record_push <= closing;
        end
    end

endmodule

// File: config_field_decoder.sv
// Configuration record field decoder
module config_field_decoder import cfg_reader_pkg::*; (
    input  logic                ap_clk,
    input  logic                rst,
    word_stream_if.monitor      words,
    input  logic                field_load,
    output logic [RECORD_W-1:0] record
);

    setup_word_u word_view;

    assign word_view = setup_word_u'(words.data);

    // ----------------------------------------
    // Field writes by window position
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            record <= '0;
        end else if (field_load) begin
            case (words.pos)
                POS_FLAGS: begin
                    record[OFF_INCREMENT]     <= word_view.flags.increment;
                    record[OFF_DECREMENT]     <= word_view.flags.decrement;
                    record[OFF_MODE_SEQUENCE] <= word_view.flags.mode_sequence;
                    record[OFF_MODE_BUFFER]   <= word_view.flags.mode_buffer;
                end
                POS_INDEX_START: begin
                    record[OFF_INDEX_START +: DATA_W] <= word_view.word;
                end
                POS_INDEX_END: begin
                    record[OFF_INDEX_END +: DATA_W] <= word_view.word;
                end
                POS_STRIDE: begin
                    record[OFF_STRIDE +: DATA_W] <= word_view.word;
                end
                // Granularity word carries shift amount and direction
                POS_GRANULARITY: begin
                    record[OFF_SHIFT_AMOUNT +: SHIFT_W] <= word_view.shift.amount;
                    record[OFF_SHIFT_LEFT]              <= word_view.shift.direction;
                end
                POS_SUBCLASS: begin
                    record[OFF_CMD +: CMD_W]    <= word_view.subclass.cmd;
                    record[OFF_BUFFER +: BUF_W] <= word_view.subclass.buffer;
                end
                POS_PTR_LO: begin
                    record[OFF_ARRAY_POINTER +: DATA_W] <= word_view.word;
                end
                POS_PTR_HI: begin
                    record[OFF_ARRAY_POINTER + DATA_W +: DATA_W] <= word_view.word;
                end
                POS_ARRAY_SIZE: begin
                    record[OFF_ARRAY_SIZE +: DATA_W] <= word_view.word;
                end
                // Unused positions leave the record alone
                default: begin
                end
            endcase
        end
    end

endmodule

// File: record_fifo.sv
// Configuration record queue
module record_fifo import cfg_reader_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic                ap_clk,
    input  logic                rst,
    input  logic                push,
    input  logic [RECORD_W-1:0] record_in,
    output logic                almost_full,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [RECORD_W-1:0] record_out
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [RECORD_W-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS-1:0] count_next;
    logic                pop;

    assign out_valid  = (count != '0);
    assign record_out = mem[rd_ptr];
    assign pop        = out_valid && out_ready;
    assign count_next = count + CNT_BITS'(push) - CNT_BITS'(pop);

    // ----------------------------------------
    // Pointers, count and almost-full
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count       <= count_next;
            // Fewer than two free entries
            almost_full <= (count_next > CNT_BITS'(DEPTH - 2));
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= record_in;
        end
    end

endmodule

// File: engine_config_reader.sv
// Engine configuration reader top
module engine_config_reader import cfg_reader_pkg::*; #(
    parameter int SEQ_BASE          = 0,
    parameter int WORD_FIFO_DEPTH   = 16,
    parameter int RECORD_FIFO_DEPTH = 4
) (
    input  logic               ap_clk,
    input  logic               rst,
    // Response word input
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [KIND_W-1:0]  in_kind,
    input  logic [INDEX_W-1:0] in_index,
    input  logic [DATA_W-1:0]  in_data,
    // Configuration output
    output logic               cfg_valid,
    input  logic               cfg_ready,
    output logic               cfg_increment,
    output logic               cfg_decrement,
    output logic               cfg_mode_sequence,
    output logic               cfg_mode_buffer,
    output logic               cfg_shift_left,
    output logic [DATA_W-1:0]  cfg_index_start,
    output logic [DATA_W-1:0]  cfg_index_end,
    output logic [DATA_W-1:0]  cfg_stride,
    output logic [DATA_W-1:0]  cfg_array_size,
    output logic [SHIFT_W-1:0] cfg_shift_amount,
    output logic [CMD_W-1:0]   cfg_cmd,
    output logic [BUF_W-1:0]   cfg_buffer,
    output logic [PTR_W-1:0]   cfg_array_pointer
);

    logic                field_load;
    logic                record_push;
    logic                record_almost_full;
    logic [RECORD_W-1:0] record_build;
    logic [RECORD_W-1:0] record_out;

    word_stream_if filtered ();
    word_stream_if queued ();

    // ----------------------------------------
    // Word path
    // ----------------------------------------
    setup_word_filter #(
        .SEQ_BASE(SEQ_BASE)
    ) setup_word_filter_inst (
        .ap_clk  (ap_clk),
        .rst     (rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_kind (in_kind),
        .in_index(in_index),
        .in_data (in_data),
        .out     (filtered)
    );

    word_fifo #(
        .DEPTH(WORD_FIFO_DEPTH)
    ) word_fifo_inst (
        .ap_clk(ap_clk),
        .rst   (rst),
        .in    (filtered),
        .out   (queued)
    );

    config_assembler_ctrl config_assembler_ctrl_inst (
        .ap_clk            (ap_clk),
        .rst               (rst),
        .words             (queued),
        .record_almost_full(record_almost_full),
        .field_load        (field_load),
        .record_push       (record_push)
    );

    config_field_decoder config_field_decoder_inst (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .words     (queued),
        .field_load(field_load),
        .record    (record_build)
    );

    // ----------------------------------------
    // Record path
    // ----------------------------------------
    record_fifo #(
        .DEPTH(RECORD_FIFO_DEPTH)
    ) record_fifo_inst (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .push       (record_push),
        .record_in  (record_build),
        .almost_full(record_almost_full),
        .out_valid  (cfg_valid),
        .out_ready  (cfg_ready),
        .record_out (record_out)
    );

    // Field split
    assign cfg_increment     = record_out[OFF_INCREMENT];
    assign cfg_decrement     = record_out[OFF_DECREMENT];
    assign cfg_mode_sequence = record_out[OFF_MODE_SEQUENCE];
    assign cfg_mode_buffer   = record_out[OFF_MODE_BUFFER];
    assign cfg_shift_left    = record_out[OFF_SHIFT_LEFT];
    assign cfg_index_start   = record_out[OFF_INDEX_START +: DATA_W];
    assign cfg_index_end     = record_out[OFF_INDEX_END +: DATA_W];
    assign cfg_stride        = record_out[OFF_STRIDE +: DATA_W];
    assign cfg_array_size    = record_out[OFF_ARRAY_SIZE +: DATA_W];
    assign cfg_shift_amount  = record_out[OFF_SHIFT_AMOUNT +: SHIFT_W];
    assign cfg_cmd           = record_out[OFF_CMD +: CMD_W];
    assign cfg_buffer        = record_out[OFF_BUFFER +: BUF_W];
    assign cfg_array_pointer = record_out[OFF_ARRAY_POINTER +: PTR_W];

endmodule

// File: tb_engine_config_reader.sv
// Engine configuration reader testbench
module tb_engine_config_reader import cfg_reader_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEQ_BASE       = 32;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int RECORD_WAIT    = 200;

    logic               ap_clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    logic [KIND_W-1:0]  in_kind;
    logic [INDEX_W-1:0] in_index;
    logic [DATA_W-1:0]  in_data;
    logic               cfg_valid;
    logic               cfg_ready;
    logic               cfg_increment;
    logic               cfg_decrement;
    logic               cfg_mode_sequence;
    logic               cfg_mode_buffer;
    logic               cfg_shift_left;
    logic [DATA_W-1:0]  cfg_index_start;
    logic [DATA_W-1:0]  cfg_index_end;
    logic [DATA_W-1:0]  cfg_stride;
    logic [DATA_W-1:0]  cfg_array_size;
    logic [SHIFT_W-1:0] cfg_shift_amount;
    logic [CMD_W-1:0]   cfg_cmd;
    logic [BUF_W-1:0]   cfg_buffer;
    logic [PTR_W-1:0]   cfg_array_pointer;

    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    integer            seed = 32'hf7f3e3b3;
    logic [DATA_W-1:0] seq_words [16];
    // Words of every sequence sent and not yet matched to a record
    logic [DATA_W-1:0] exp_words [$];

    engine_config_reader #(
        .SEQ_BASE(SEQ_BASE)
    ) engine_config_reader_inst (
        .ap_clk(ap_clk), .rst(rst),
        .in_valid(in_valid), .in_ready(in_ready), .in_kind(in_kind),
        .in_index(in_index), .in_data(in_data),
        .cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
        .cfg_increment(cfg_increment), .cfg_decrement(cfg_decrement),
        .cfg_mode_sequence(cfg_mode_sequence), .cfg_mode_buffer(cfg_mode_buffer),
        .cfg_shift_left(cfg_shift_left), .cfg_index_start(cfg_index_start),
        .cfg_index_end(cfg_index_end), .cfg_stride(cfg_stride),
        .cfg_array_size(cfg_array_size), .cfg_shift_amount(cfg_shift_amount),
        .cfg_cmd(cfg_cmd), .cfg_buffer(cfg_buffer),
        .cfg_array_pointer(cfg_array_pointer)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic fill_random_sequence();
        for (int p = 0; p < 16; p++) begin
            seq_words[p] = $random(seed);
        end
    endtask

    // Returns with the word on the bus; it transfers on the next rising edge
    task automatic send_word(input logic [KIND_W-1:0] kind, input logic [INDEX_W-1:0] index,
                             input logic [DATA_W-1:0] data);
        @(negedge ap_clk);
        in_valid = 1'b1;
        in_kind  = kind;
        in_index = index;
        in_data  = data;
        while (!in_ready) @(negedge ap_clk);
    endtask

    task automatic release_input();
        @(negedge ap_clk);
        in_valid = 1'b0;
    endtask

    // Indices SEQ_BASE to SEQ_BASE+15 with the two setup kinds in turn
    task automatic send_sequence();
        for (int p = 0; p < 16; p++) begin
            exp_words.push_back(seq_words[p]);
            send_word(p[0] ? KIND_ENGINE_SETUP : KIND_CU_SETUP, INDEX_W'(SEQ_BASE + p),
                      seq_words[p]);
        end
    endtask

    task automatic wait_for_record(output logic found);
        int n;
        n = 0;
        @(negedge ap_clk);
        while (!cfg_valid && n < RECORD_WAIT) begin
            @(negedge ap_clk);
            n++;
        end
        found = cfg_valid;
    endtask

    // Reference fields straight from the word layout of each position
    task automatic check_record(input logic [DATA_W-1:0] w [16], input string tag);
        check_value(cfg_increment, w[0][0], {tag, ": increment"});
        check_value(cfg_decrement, w[0][1], {tag, ": decrement"});
        check_value(cfg_mode_sequence, w[0][2], {tag, ": mode_sequence"});
        check_value(cfg_mode_buffer, w[0][3], {tag, ": mode_buffer"});
        check_value(cfg_index_start, w[1], {tag, ": index_start"});
        check_value(cfg_index_end, w[2], {tag, ": index_end"});
        check_value(cfg_stride, w[3], {tag, ": stride"});
        check_value(cfg_shift_amount, w[4][30:0], {tag, ": shift_amount"});
        check_value(cfg_shift_left, w[4][31], {tag, ": shift_left"});
        check_value(cfg_cmd, w[5][3:0], {tag, ": cmd"});
        check_value(cfg_buffer, w[5][7:4], {tag, ": buffer"});
        check_value(cfg_array_pointer, {w[9], w[8]}, {tag, ": array_pointer"});
        check_value(cfg_array_size, w[10], {tag, ": array_size"});
    endtask

    task automatic expect_record(input string tag);
        logic [DATA_W-1:0] w [16];
        logic              found;
        wait_for_record(found);
        if (!found) begin
            errors++;
            $display("ERROR: no record appeared for %s within %0d cycles", tag, RECORD_WAIT);
        end else if (exp_words.size() < 16) begin
            errors++;
            $display("ERROR: a record appeared for %s with no sequence left to match", tag);
        end else begin
            for (int p = 0; p < 16; p++) begin
                w[p] = exp_words.pop_front();
            end
            check_record(w, tag);
            cfg_ready = 1'b1;
            @(negedge ap_clk);
            cfg_ready = 1'b0;
        end
    endtask

    task automatic check_no_record(input string tag);
        logic seen;
        seen = 1'b0;
        repeat (40) begin
            @(negedge ap_clk);
            seen = seen | cfg_valid;
        end
        check_value(seen, 1'b0, {tag, ": unexpected extra record"});
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset();
        check_value(cfg_valid, 1'b0, "reset: cfg_valid");
        check_value({cfg_increment, cfg_decrement, cfg_mode_sequence, cfg_mode_buffer,
                     cfg_shift_left}, 5'b0, "reset: flag outputs");
        check_value({cfg_index_start, cfg_index_end}, 64'h0, "reset: index range");
        check_value({cfg_stride, cfg_array_size}, 64'h0, "reset: stride and size");
        check_value({cfg_shift_amount, cfg_cmd, cfg_buffer}, 64'h0, "reset: shift and subclass");
        check_value(cfg_array_pointer, 64'h0, "reset: array_pointer");
    endtask

    task automatic test_single_sequence();
        fill_random_sequence();
        send_sequence();
        release_input();
        expect_record("single sequence");
        check_no_record("single sequence");
    endtask

    task automatic decode_case(input logic [DATA_W-1:0] gran, input logic [DATA_W-1:0] sub,
                               input logic left, input logic [30:0] amount,
                               input logic [3:0] cmd, input logic [3:0] buffer);
        logic found;
        fill_random_sequence();
        seq_words[4] = gran;
        seq_words[5] = sub;
        send_sequence();
        release_input();
        wait_for_record(found);
        check_value(found, 1'b1, "union decode: record present");
        check_value(cfg_shift_left, left, "union decode: shift_left");
        check_value(cfg_shift_amount, amount, "union decode: shift_amount");
        check_value(cfg_cmd, cmd, "union decode: cmd");
        check_value(cfg_buffer, buffer, "union decode: buffer");
        expect_record("union decode");
    endtask

    task automatic test_union_decode();
        decode_case(32'haa5a_1c3f, 32'h5a3c_e16b, 1'b1, 31'h2a5a_1c3f, 4'hb, 4'h6);
        decode_case(32'h0000_0007, 32'h0000_00c3, 1'b0, 31'h0000_0007, 4'h3, 4'hc);
    endtask

    // Foreign kinds and out-of-window indices mixed into one sequence
    task automatic test_filtering();
        fill_random_sequence();
        send_word(KIND_ENGINE_SETUP, INDEX_W'(SEQ_BASE - 1), $random(seed));
        for (int p = 0; p < 16; p++) begin
            if (p == 15) begin
                send_word(KIND_CU_SETUP, INDEX_W'(SEQ_BASE + 16), $random(seed));
            end
            exp_words.push_back(seq_words[p]);
            send_word(KIND_CU_SETUP, INDEX_W'(SEQ_BASE + p), seq_words[p]);
            // A leaked foreign word would overwrite the field just written
            if (p % 4 == 0) begin
                send_word(4'h3, INDEX_W'(SEQ_BASE + p), $random(seed));
            end
        end
        send_word(4'h0, INDEX_W'(SEQ_BASE + 15), $random(seed));
        release_input();
        expect_record("filtering");
        check_no_record("filtering");
    endtask

    task automatic test_back_pressure();
        logic stalled;
        int   n;
        fork
            begin
                for (int s = 0; s < 6; s++) begin
                    fill_random_sequence();
                    send_sequence();
                end
                release_input();
            end
            begin
                stalled = 1'b0;
                n = 0;
                while (!stalled && n < 400) begin
                    @(negedge ap_clk);
                    stalled = !in_ready;
                    n++;
                end
                check_value(stalled, 1'b1, "back-pressure: in_ready went low");
                for (int r = 0; r < 6; r++) begin
                    expect_record($sformatf("back-pressure record %0d", r));
                end
            end
        join
        check_no_record("back-pressure");
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_kind   = '0;
        in_index  = '0;
        in_data   = '0;
        cfg_ready = 1'b0;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;
        @(negedge ap_clk);
        test_reset();
        test_single_sequence();
        test_union_decode();
        test_filtering();
        test_back_pressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
cfg_reader_pkg.sv
word_stream_if.sv
setup_word_filter.sv
word_fifo.sv
config_assembler_ctrl.sv
config_field_decoder.sv
record_fifo.sv
engine_config_reader.sv
tb_engine_config_reader.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_engine_config_reader -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_engine_config_reader > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run exited with status $run_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
